// File: Bender.yml
package:
  name: laser500_board

sources:
  # Shared package first
  - hw/laser500_pkg.sv
  # Board blocks
  - hw/ram_eraser.sv
  - hw/memory_access_control.sv
  - hw/sigma_delta_dac.sv
  - hw/cassette_audio.sv
  # Top level
  - hw/laser500_board.sv
  # Simulation only
  - target: test
    files:
      - tests/tb_laser500_board.sv

// File: hw/cassette_audio.sv
// Cassette input latch and buzzer/tape audio mix driven out through the one-bit DAC
`timescale 1ns/100ps

module cassette_audio
	import laser500_pkg::*;
(
	input  logic F14M,
	input  logic rst_n,
	input  logic uart_rx,  // Tape signal in, inverted on the board
	input  logic buzzer,   // Keyboard speaker
	input  logic casout,   // Tape save line
	output logic casin,    // Back to the video chip
	output logic audio_l,
	output logic audio_r
);

	logic                mix;     // All three sources in one bit
	logic [DAC_BITS-1:0] dac_in;
	logic                dac_bit;

	// Tape input latch
	always_ff @(posedge F14M or negedge rst_n) begin
		if (!rst_n)
			casin <= 1'b0;
		else
			casin <= ~uart_rx;
	end

	assign mix    = buzzer ^ casin ^ ~casout;
	assign dac_in = {mix, {(DAC_BITS - 1){1'b0}}}; // Half scale or silence

	sigma_delta_dac u_dac (
		.F14M    ( F14M    ),
		.rst_n   ( rst_n   ),
		.dac_in  ( dac_in  ),
		.dac_out ( dac_bit )
	);

	// Same stream on both channels
	always_ff @(posedge F14M or negedge rst_n) begin
		if (!rst_n) begin
			audio_l <= 1'b0;
			audio_r <= 1'b0;
		end else begin
			audio_l <= dac_bit;
			audio_r <= dac_bit;
		end
	end

endmodule

// File: hw/laser500_board.sv
// Laser 350/500/700 board glue: RAM eraser, SDRAM port sharing, reset/blank and audio
`timescale 1ns/100ps

module laser500_board
	import laser500_pkg::*;
(
	input  logic              F14M,           // Main 14 MHz clock
	input  logic              rst_n,
	// Control from menu, downloader and keyboard
	input  logic              erase_trigger,
	input  logic              downloading,
	input  logic              boot_completed,
	input  logic              reset_key,
	input  logic [HCNT_W-1:0] hcnt,           // From the video chip
	// Requesters
	input  mem_req_t          dl_req,
	input  mem_req_t          vdc_req,
	// Sound sources
	input  logic              uart_rx,
	input  logic              buzzer,
	input  logic              casout,
	// To SDRAM controller
	output mem_req_t          sdram_req,
	output logic              cpu_reset,
	output logic              blank,
	output logic              casin,
	output logic              audio_l,
	output logic              audio_r
);

	logic     erasing;
	mem_req_t erase_req;

	// RAM clear after menu reset
	ram_eraser u_eraser (
		.F14M          ( F14M          ),
		.rst_n         ( rst_n         ),
		.erase_trigger ( erase_trigger ),
		.hcnt          ( hcnt          ),
		.erasing       ( erasing       ),
		.erase_req     ( erase_req     )
	);

	// Port owner and CPU/video hold
	memory_access_control u_access (
		.downloading    ( downloading    ),
		.erasing        ( erasing        ),
		.boot_completed ( boot_completed ),
		.reset_key      ( reset_key      ),
		.dl_req         ( dl_req         ),
		.erase_req      ( erase_req      ),
		.vdc_req        ( vdc_req        ),
		.sdram_req      ( sdram_req      ),
		.cpu_reset      ( cpu_reset      ),
		.blank          ( blank          )
	);

	// Tape in and sound out
	cassette_audio u_audio (
		.F14M    ( F14M    ),
		.rst_n   ( rst_n   ),
		.uart_rx ( uart_rx ),
		.buzzer  ( buzzer  ),
		.casout  ( casout  ),
		.casin   ( casin   ),
		.audio_l ( audio_l ),
		.audio_r ( audio_r )
	);

endmodule

// File: hw/laser500_pkg.sv
// Shared types and constants for the Laser 500 board core, imported by every block
package laser500_pkg;

	// SDRAM port geometry
	localparam int SDRAM_AW = 25;                // Byte address width
	localparam int SDRAM_DW = 8;                 // Byte-wide data

	// One request on the single SDRAM port
	typedef struct packed {
		logic [SDRAM_AW-1:0] addr;               // Byte address
		logic [SDRAM_DW-1:0] data;               // Write byte
		logic                wr;                 // Write strobe, one cycle per byte
		logic                rd;                 // Read enable level
	} mem_req_t;

	// Character clock phase from the video chip
	localparam int HCNT_W = 3;

	// Eraser writes only on this phase, leaving the rest to the video chip
	localparam logic [HCNT_W-1:0] ERASE_SLOT = 3'd6;

	// Machine RAM window cleared by the menu reset
	localparam logic [SDRAM_AW-1:0] ERASE_BASE = '0;
	localparam int ERASE_WORDS = 65536;          // 64K of RAM

	// Counter must also hold ERASE_WORDS itself
	localparam int ERASE_CNT_W = $clog2(ERASE_WORDS) + 1;

	// Fill byte
	localparam logic [SDRAM_DW-1:0] ERASE_FILL = 8'h00;

	// Delta-sigma input word
	localparam int DAC_BITS = 16;

	// Notes
	// Priority on the port is download, then eraser, then video chip
	// The SDRAM controller takes one request per F14M cycle
	// No back-pressure on any requester
	// Eraser rate is one byte per eight F14M cycles
	// Audio is a single bit, so the DAC only sees its top input bit
	// Left and right channels carry the same stream

endpackage

// File: hw/memory_access_control.sv
// SDRAM port arbitration between download, eraser and video chip, plus CPU reset and blank
`timescale 1ns/100ps

module memory_access_control
	import laser500_pkg::*;
(
	input  logic     downloading,    // ROM download in progress
	input  logic     erasing,        // RAM eraser busy
	input  logic     boot_completed, // ROM image loaded
	input  logic     reset_key,      // Reset key on the keyboard
	input  mem_req_t dl_req,
	input  mem_req_t erase_req,
	input  mem_req_t vdc_req,
	output mem_req_t sdram_req,
	output logic     cpu_reset,
	output logic     blank
);

	logic foreign_owner; // Someone other than the video chip has the RAM

	// Fixed priority, download first
	always_comb begin
		if (downloading) begin
			sdram_req    = dl_req;
			sdram_req.rd = 1'b1;
		end else if (erasing) begin
			sdram_req    = erase_req;
			sdram_req.rd = 1'b1;
		end else begin
			sdram_req = vdc_req; // Video/CPU chip as is
		end
	end

	// Not booted counts as well, RAM content is not valid yet
	assign foreign_owner = ~boot_completed | downloading | erasing;

	// Screen dark while RAM is busy elsewhere
	assign blank = foreign_owner;

	// CPU held, also by the reset key
	assign cpu_reset = foreign_owner | reset_key;

endmodule

// File: hw/ram_eraser.sv
// Clears the machine RAM after a menu reset, one byte per character clock slot
`timescale 1ns/100ps

module ram_eraser
	import laser500_pkg::*;
(
	input  logic              F14M,
	input  logic              rst_n,
	input  logic              erase_trigger, // Menu reset, level
	input  logic [HCNT_W-1:0] hcnt,          // Character clock phase
	output logic              erasing,       // Eraser owns the RAM
	output mem_req_t          erase_req
);

	logic                   trig_q;          // Previous trigger sample
	logic                   trig_rise;
	logic                   slot_hit;        // Write slot this cycle
	logic                   last_write;
	logic [ERASE_CNT_W-1:0] cnt;             // Bytes written so far

	assign trig_rise  = erase_trigger & ~trig_q;
	assign slot_hit   = erasing && (hcnt == ERASE_SLOT);
	assign last_write = slot_hit && (cnt == ERASE_CNT_W'(ERASE_WORDS - 1));

	// Edge detect on the trigger
	always_ff @(posedge F14M or negedge rst_n) begin
		if (!rst_n)
			trig_q <= 1'b0;
		else
			trig_q <= erase_trigger;
	end

	// Busy flag and byte counter
	always_ff @(posedge F14M or negedge rst_n) begin
		if (!rst_n) begin
			erasing <= 1'b0;
			cnt     <= '0;
		end else if (!erasing) begin
			if (trig_rise) begin // New run from the base
				erasing <= 1'b1;
				cnt     <= '0;
			end
		end else if (slot_hit) begin
			cnt <= cnt + 1'b1;
			if (last_write)
				erasing <= 1'b0; // Port released on the edge after the last byte
		end
	end

	// Request toward the access control
	always_comb begin
		erase_req.addr = ERASE_BASE + SDRAM_AW'(cnt); // Current byte
		erase_req.data = ERASE_FILL;
		erase_req.wr   = slot_hit;                    // Single-cycle strobe
		erase_req.rd   = erasing;                     // Forced high downstream anyway
	end

endmodule

// File: hw/sigma_delta_dac.sv
// First-order delta-sigma converter turning an audio word into a one-bit stream
`timescale 1ns/100ps

module sigma_delta_dac
	import laser500_pkg::*;
(
	input  logic                F14M,
	input  logic                rst_n,
	input  logic [DAC_BITS-1:0] dac_in,  // Unsigned sample
	output logic                dac_out  // Pulse density stream
);

	// Extra top bit is the carry
	logic [DAC_BITS:0] acc;
	logic [DAC_BITS:0] sum;

	// Input plus the residue of the last step
	assign sum = {1'b0, dac_in} + {1'b0, acc[DAC_BITS-1:0]};

	always_ff @(posedge F14M or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= sum; // Every cycle, no enable
	end

	// Carry out gives the one-bit output
	// Density of ones is dac_in / 2**DAC_BITS
	assign dac_out = acc[DAC_BITS];

	// Half scale input gives 0101...
	// Zero input keeps the carry low forever

endmodule

// File: laser500_board.f
hw/laser500_pkg.sv
hw/ram_eraser.sv
hw/memory_access_control.sv
hw/sigma_delta_dac.sv
hw/cassette_audio.sv
hw/laser500_board.sv
tests/tb_laser500_board.sv

// File: tests/tb_laser500_board.sv
// Self-checking testbench for the Laser 500 board core, run as the simulation top
`timescale 1ns/100ps

module tb_laser500_board;
	import laser500_pkg::*;

	localparam int ERASE_TIMEOUT = ERASE_WORDS * 8 + 400; // Cycle budget including the download pause

	// One row of the port priority table
	typedef struct packed {
		logic     downloading;
		logic     boot_completed;
		logic     reset_key;
		mem_req_t dl_req;
		mem_req_t vdc_req;
		mem_req_t exp_req;
		logic     exp_cpu_reset;
		logic     exp_blank;
	} row_t;

	logic              F14M = 1'b0;
	logic              rst_n;
	logic              erase_trigger;
	logic              downloading;
	logic              boot_completed;
	logic              reset_key;
	logic [HCNT_W-1:0] hcnt = '0;
	mem_req_t          dl_req;
	mem_req_t          vdc_req;
	logic              uart_rx;
	logic              buzzer;
	logic              casout;
	mem_req_t          sdram_req;
	logic              cpu_reset;
	logic              blank;
	logic              casin;
	logic              audio_l;
	logic              audio_r;

	integer seed = 32'ha20a_3813;
	int     errors;
	int     checks;
	int     tests;
	int     test_errors;
	logic   hung;                    // Some wait ran out
	row_t   table_rows [0:7];

	laser500_board u_dut (.*);

	initial begin
		forever #2 F14M = ~F14M;
	end

	// Free running character clock phase 0..7
	always @(negedge F14M) hcnt <= hcnt + 1'b1;

	function automatic mem_req_t rand_req();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[$bits(mem_req_t)-1:0];
	endfunction

	// Expected port owner from the priority rule
	function automatic row_t make_row(input logic dl, input logic boot, input logic key,
			input logic cpu, input logic blk);
		row_t r;
		r.downloading    = dl;
		r.boot_completed = boot;
		r.reset_key      = key;
		r.dl_req         = rand_req();
		r.vdc_req        = rand_req();
		if (dl) begin
			r.exp_req    = r.dl_req;
			r.exp_req.rd = 1'b1;         // Download reads forced on
		end else begin
			r.exp_req = r.vdc_req;
		end
		r.exp_cpu_reset = cpu;
		r.exp_blank     = blk;
		return r;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			$display("** Error: %s expected %0h actual %0h", name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic test_done(input string name);
		tests++;
		$display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "mismatches",
			test_errors);
		test_errors = 0;
	endtask

	task automatic drive_table(input string name, input int first, input int last);
		for (int i = first; i <= last; i++) begin
			@(negedge F14M);
			downloading    = table_rows[i].downloading;
			boot_completed = table_rows[i].boot_completed;
			reset_key      = table_rows[i].reset_key;
			dl_req         = table_rows[i].dl_req;
			vdc_req        = table_rows[i].vdc_req;
			#1; // Combinational outputs settle in the same cycle
			check({name, " sdram_req"}, table_rows[i].exp_req, sdram_req);
			check({name, " cpu_reset"}, table_rows[i].exp_cpu_reset, cpu_reset);
			check({name, " blank"}, table_rows[i].exp_blank, blank);
		end
		test_done(name);
	endtask

	// Erase run with an optional retrigger and download in the middle
	task automatic exercise_erase(input string name, input logic disturb);
		int       cycles;
		int       slots;                 // Slot cycles seen while erasing
		int       writes;                // Writes seen on the port
		mem_req_t dl_now;
		cycles = 0;
		slots  = 0;
		writes = 0;
		@(negedge F14M);
		downloading    = 1'b0;
		boot_completed = 1'b1;
		reset_key      = 1'b0;
		vdc_req        = rand_req();
		vdc_req.wr     = 1'b0;           // Only eraser writes may show up
		erase_trigger  = 1'b1;
		@(negedge F14M);
		erase_trigger = 1'b0;
		#1;
		check({name, " erasing rose"}, 1'b1, u_dut.erasing);
		while (u_dut.erasing && cycles < ERASE_TIMEOUT) begin
			check({name, " blank"}, 1'b1, blank);
			check({name, " cpu_reset"}, 1'b1, cpu_reset);
			if (downloading) begin
				dl_now    = dl_req;
				dl_now.rd = 1'b1;
				check({name, " download owner"}, dl_now, sdram_req);
			end else begin
				check({name, " wr on slot"}, hcnt == ERASE_SLOT, sdram_req.wr);
				if (sdram_req.wr) begin
					check({name, " addr"}, ERASE_BASE + slots, sdram_req.addr);
					check({name, " data"}, ERASE_FILL, sdram_req.data);
					check({name, " rd"}, 1'b1, sdram_req.rd);
					writes++;
				end
			end
			if (hcnt == ERASE_SLOT)
				slots++;           // Counter moves on even under a download
			@(negedge F14M);
			cycles++;
			if (disturb) begin
				erase_trigger = (cycles >= 800 && cycles < 802);   // Ignored retrigger
				downloading   = (cycles >= 2000 && cycles < 2040);
				dl_req        = rand_req();
			end
			#1;
		end
		if (u_dut.erasing) begin
			$display("Timeout: erase still running after %0d cycles", ERASE_TIMEOUT);
			hung = 1'b1;
		end else begin
			check({name, " slot count"}, ERASE_WORDS, slots);
			if (!disturb)
				check({name, " writes"}, ERASE_WORDS, writes);
			check({name, " port back to video"}, vdc_req, sdram_req);
		end
		test_done(name);
	endtask

	task automatic probe_casin(input string name);
		logic rx;
		logic exp_casin;
		for (int i = 0; i < 32; i++) begin
			@(negedge F14M);
			rx        = $random(seed);
			uart_rx   = rx;
			exp_casin = ~rx;
			@(negedge F14M);           // One register stage
			check({name, " casin"}, exp_casin, casin);
		end
		test_done(name);
	endtask

	task automatic measure_audio(input string name);
		logic mix;
		logic in_range;
		int   ones;
		for (int k = 0; k < 8; k++) begin
			@(negedge F14M);
			buzzer  = k[0];
			uart_rx = k[1];
			casout  = k[2];
			mix     = k[0] ^ ~k[1] ^ ~k[2];      // casin is the inverted uart_rx
			repeat (8) @(negedge F14M);        // Latch, DAC and output stage
			ones = 0;
			for (int c = 0; c < 512; c++) begin
				@(negedge F14M);
				check({name, " left equals right"}, audio_l, audio_r);
				ones += audio_l;
			end
			in_range = mix ? (ones >= 255 && ones <= 257) : (ones == 0);
			check($sformatf("%s ones=%0d mix=%0d", name, ones, mix), 1'b1, in_range);
		end
		test_done(name);
	endtask

	initial begin
		rst_n          = 1'b0;
		erase_trigger  = 1'b0;
		downloading    = 1'b0;
		boot_completed = 1'b0;
		reset_key      = 1'b0;
		dl_req         = '0;
		vdc_req        = '0;
		uart_rx        = 1'b1;
		buzzer         = 1'b0;
		casout         = 1'b0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		test_errors    = 0;
		hung           = 1'b0;
		// downloading, boot, key, cpu_reset, blank
		table_rows[0] = make_row(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		table_rows[1] = make_row(1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
		table_rows[2] = make_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
		table_rows[3] = make_row(1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
		table_rows[4] = make_row(1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
		table_rows[5] = make_row(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		table_rows[6] = make_row(1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
		table_rows[7] = make_row(1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
		repeat (3) @(negedge F14M);
		rst_n = 1'b1;
		drive_table("prio_video", 0, 3);
		drive_table("prio_download", 4, 7);
		if (!hung)
			exercise_erase("erase", 1'b0);
		if (!hung)
			exercise_erase("erase_pause", 1'b1);
		probe_casin("casin");
		measure_audio("audio");
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !hung)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
